// ==== rtl/cpu_pkg.sv ====
// cpu package
// widths, opcodes, ALU select codes, branch codes, FSM states
// and the instruction word with its two field layouts

package cpu_pkg;

    localparam int data_w  = 8;                    // datapath width
    localparam int instr_w = 32;                   // instruction word
    localparam int reg_aw  = 3;                    // eight registers
    localparam int pc_w    = 8;                    // program counter

    // opcodes
    localparam logic [7:0] op_loadi = 8'd0;
    localparam logic [7:0] op_mov   = 8'd1;
    localparam logic [7:0] op_add   = 8'd2;
    localparam logic [7:0] op_sub   = 8'd3;
    localparam logic [7:0] op_and   = 8'd4;
    localparam logic [7:0] op_or    = 8'd5;
    localparam logic [7:0] op_j     = 8'd6;
    localparam logic [7:0] op_beq   = 8'd7;
    localparam logic [7:0] op_mult  = 8'd12;
    localparam logic [7:0] op_sll   = 8'd13;
    localparam logic [7:0] op_srl   = 8'd14;
    localparam logic [7:0] op_sra   = 8'd15;
    localparam logic [7:0] op_ror   = 8'd16;
    localparam logic [7:0] op_bne   = 8'd17;

    // alu select
    localparam logic [2:0] alu_fwd = 3'd0;         // pass operand b
    localparam logic [2:0] alu_add = 3'd1;
    localparam logic [2:0] alu_and = 3'd2;
    localparam logic [2:0] alu_or  = 3'd3;
    localparam logic [2:0] alu_mul = 3'd4;
    localparam logic [2:0] alu_lsh = 3'd5;         // sll or srl by shift bit
    localparam logic [2:0] alu_sra = 3'd6;
    localparam logic [2:0] alu_ror = 3'd7;

    // branch kind
    localparam logic [1:0] br_none = 2'd0;
    localparam logic [1:0] br_eq   = 2'd1;
    localparam logic [1:0] br_ne   = 2'd2;

    // fetch / execute states
    localparam logic [1:0] st_req  = 2'd0;         // req high, wait ack
    localparam logic [1:0] st_rel  = 2'd1;         // req dropped
    localparam logic [1:0] st_low  = 2'd2;         // wait ack low
    localparam logic [1:0] st_exec = 2'd3;         // one cycle

    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] rd;
        logic [7:0] rt;
        logic [7:0] rs;                            // also immediate
    } r_fmt_t;

    typedef struct packed {
        logic [7:0]        opcode;
        logic signed [7:0] offset;                 // instruction count
        logic [7:0]        rt;
        logic [7:0]        rs;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;                                 // alu / load forms
        b_fmt_t b;                                 // j, beq, bne
    } instr_t;

endpackage

// ==== rtl/control_unit.sv ====
// control unit
// decodes the opcode into write enable, operand selects, ALU select,
// jump, branch kind and shift direction

module control_unit (
    input  logic [7:0] opcode,
    output logic       write_enable,
    output logic       comp_select,
    output logic       imm_select,
    output logic       jump,
    output logic       shift_left,
    output logic [1:0] branch,
    output logic [2:0] alu_op
);

    import cpu_pkg::*;

    always_comb begin
        write_enable = 1'b0;                       // unknown opcode is a no-op
        comp_select  = 1'b0;
        imm_select   = 1'b0;
        jump         = 1'b0;
        shift_left   = 1'b0;
        branch       = br_none;
        alu_op       = alu_fwd;

        case (opcode)
            op_loadi: begin
                write_enable = 1'b1;
                imm_select   = 1'b1;               // forward the immediate
            end
            op_mov: begin
                write_enable = 1'b1;               // forward rs data
            end
            op_add: begin
                write_enable = 1'b1;
                alu_op       = alu_add;
            end
            op_sub: begin
                write_enable = 1'b1;
                comp_select  = 1'b1;               // rt + (-rs)
                alu_op       = alu_add;
            end
            op_and: begin
                write_enable = 1'b1;
                alu_op       = alu_and;
            end
            op_or: begin
                write_enable = 1'b1;
                alu_op       = alu_or;
            end
            op_mult: begin
                write_enable = 1'b1;
                alu_op       = alu_mul;
            end
            op_sll: begin
                write_enable = 1'b1;
                imm_select   = 1'b1;               // shift amount
                alu_op       = alu_lsh;
                shift_left   = 1'b1;
            end
            op_srl: begin
                write_enable = 1'b1;
                imm_select   = 1'b1;
                alu_op       = alu_lsh;
            end
            op_sra: begin
                write_enable = 1'b1;
                imm_select   = 1'b1;
                alu_op       = alu_sra;
            end
            op_ror: begin
                write_enable = 1'b1;
                imm_select   = 1'b1;
                alu_op       = alu_ror;
            end
            op_j: begin
                jump         = 1'b1;
            end
            op_beq: begin
                comp_select  = 1'b1;               // compare by subtract
                alu_op       = alu_add;
                branch       = br_eq;
            end
            op_bne: begin
                comp_select  = 1'b1;
                alu_op       = alu_add;
                branch       = br_ne;
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/alu.sv ====
// alu
// forward, add, and, or, low-byte multiply, logical and arithmetic
// shifts and rotate right, plus a zero flag for branches

module alu (
    input  logic [cpu_pkg::data_w-1:0] operand_a,
    input  logic [cpu_pkg::data_w-1:0] operand_b,
    input  logic [2:0]                 alu_op,
    input  logic                       shift_left,
    output logic [cpu_pkg::data_w-1:0] result,
    output logic                       zero
);

    import cpu_pkg::*;

    logic [2:0]          shamt;                    // low bits of operand b
    logic [2*data_w-1:0] rot_pair;                 // a:a for rotate

    assign shamt    = operand_b[2:0];
    assign rot_pair = {operand_a, operand_a} >> shamt;

    always_comb begin
        case (alu_op)
            alu_fwd: result = operand_b;
            alu_add: result = operand_a + operand_b;
            alu_and: result = operand_a & operand_b;
            alu_or:  result = operand_a | operand_b;
            alu_mul: result = data_w'(operand_a * operand_b);  // low byte only
            alu_lsh: begin
                if (shift_left) begin
                    result = operand_a << shamt;
                end else begin
                    result = operand_a >> shamt;
                end
            end
            alu_sra: result = $signed(operand_a) >>> shamt;   // sign fill
            alu_ror: result = rot_pair[data_w-1:0];
            default: result = operand_b;
        endcase
    end

    assign zero = (result == '0);                  // beq / bne test

endmodule

// ==== rtl/reg_file.sv ====
// register file
// eight 8-bit registers, two asynchronous read ports, one write port

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       write_en,
    input  logic [cpu_pkg::reg_aw-1:0] write_addr,
    input  logic [cpu_pkg::data_w-1:0] write_data,
    input  logic [cpu_pkg::reg_aw-1:0] read_addr_a,
    input  logic [cpu_pkg::reg_aw-1:0] read_addr_b,
    output logic [cpu_pkg::data_w-1:0] read_data_a,
    output logic [cpu_pkg::data_w-1:0] read_data_b
);

    import cpu_pkg::*;

    logic [data_w-1:0] regs [0:(1<<reg_aw)-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << reg_aw); i++) begin
                regs[i] <= '0;                     // all clear
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    assign read_data_a = regs[read_addr_a];        // rt
    assign read_data_b = regs[read_addr_b];        // rs

endmodule

// ==== rtl/pc_unit.sv ====
// program counter
// steps by one, or by one plus a signed offset on jump or taken branch

module pc_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     step,
    input  logic                     jump,
    input  logic [1:0]               branch,
    input  logic                     zero,
    input  logic [7:0]               offset,
    output logic [cpu_pkg::pc_w-1:0] pc
);

    import cpu_pkg::*;

    logic            take;                         // redirect this step
    logic [pc_w-1:0] pc_next;

    assign take = jump
                | ((branch == br_eq) &&  zero)
                | ((branch == br_ne) && !zero);

    // offset counts from the following instruction
    assign pc_next = pc + pc_w'(1) + (take ? pc_w'($signed(offset)) : '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (step) begin
            pc <= pc_next;                         // only in execute
        end
    end

endmodule

// ==== rtl/cpu_fsm.sv ====
// fetch / execute sequencer
// runs the four-phase req/ack fetch, holds the instruction register
// and flags the single execute cycle

module cpu_fsm (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            imem_ack,
    input  cpu_pkg::instr_t imem_data,
    output logic            imem_req,
    output cpu_pkg::instr_t instr,
    output logic            exec
);

    import cpu_pkg::*;

    logic [1:0] state;
    logic [1:0] state_next;

    always_comb begin
        state_next = state;
        case (state)
            st_req:  if (imem_ack) state_next = st_rel;    // data valid now
            st_rel:  state_next = st_low;          // memory has not seen req drop yet
            st_low:  if (!imem_ack) state_next = st_exec;  // handshake closed
            st_exec: state_next = st_req;          // next fetch
            default: state_next = st_req;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_req;
            imem_req <= 1'b0;                      // no fetch in reset
        end else begin
            state    <= state_next;
            imem_req <= (state_next == st_req);    // phase 1 and 2
        end
    end

    // capture on the ack edge while the memory holds the data
    always_ff @(posedge clk) begin
        if (state == st_req && imem_ack) begin
            instr <= imem_data;
        end
    end

    assign exec = (state == st_exec);

endmodule

// ==== rtl/cpu_top.sv ====
// cpu top level
// fetch sequencer, program counter, decoder, register file and ALU,
// with the operand mux and the write-back port

module cpu_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       imem_ack,
    input  cpu_pkg::instr_t            imem_data,
    output logic                       imem_req,
    output logic [cpu_pkg::pc_w-1:0]   imem_addr,
    output logic                       retire,
    output logic                       wb_en,
    output logic [cpu_pkg::reg_aw-1:0] wb_addr,
    output logic [cpu_pkg::data_w-1:0] wb_data
);

    import cpu_pkg::*;

    instr_t            instr;                      // latched word
    logic              exec;
    logic              write_enable;
    logic              comp_select;
    logic              imm_select;
    logic              jump;
    logic              shift_left;
    logic [1:0]        branch;
    logic [2:0]        alu_op;
    logic [data_w-1:0] rt_data;
    logic [data_w-1:0] rs_data;
    logic [data_w-1:0] rs_neg;
    logic [data_w-1:0] operand_b;
    logic [data_w-1:0] alu_result;
    logic              zero;

    cpu_fsm u_cpu_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .imem_req  (imem_req),
        .instr     (instr),
        .exec      (exec)
    );

    control_unit u_control_unit (
        .opcode       (instr.r.opcode),
        .write_enable (write_enable),
        .comp_select  (comp_select),
        .imm_select   (imm_select),
        .jump         (jump),
        .shift_left   (shift_left),
        .branch       (branch),
        .alu_op       (alu_op)
    );

    reg_file u_reg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_en    (wb_en),
        .write_addr  (wb_addr),
        .write_data  (alu_result),
        .read_addr_a (instr.r.rt[reg_aw-1:0]),     // low bits of field
        .read_addr_b (instr.r.rs[reg_aw-1:0]),
        .read_data_a (rt_data),
        .read_data_b (rs_data)
    );

    assign rs_neg    = ~rs_data + 1'b1;            // two's complement
    assign operand_b = imm_select  ? instr.r.rs :  // immediate field
                       comp_select ? rs_neg     : rs_data;

    alu u_alu (
        .operand_a  (rt_data),
        .operand_b  (operand_b),
        .alu_op     (alu_op),
        .shift_left (shift_left),
        .result     (alu_result),
        .zero       (zero)
    );

    pc_unit u_pc_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .step   (exec),
        .jump   (jump),
        .branch (branch),
        .zero   (zero),
        .offset (instr.b.offset),                  // b view for j / beq / bne
        .pc     (imem_addr)
    );

    assign retire  = exec;
    assign wb_en   = write_enable & exec;          // write only in execute
    assign wb_addr = instr.r.rd[reg_aw-1:0];
    assign wb_data = alu_result;

endmodule

// ==== verif/imem_model.sv ====
// instruction memory responder
// answers the four-phase req/ack fetch with a random 0 to 3 cycle
// wait before each ack edge, words come from the program array

module imem_model (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  logic [cpu_pkg::pc_w-1:0] addr,
    output logic                     ack,
    output cpu_pkg::instr_t          data
);

    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam logic [1:0] ph_idle = 2'd0;         // wait for req
    localparam logic [1:0] ph_up   = 2'd1;         // delay before ack rise
    localparam logic [1:0] ph_hold = 2'd2;         // ack high, wait req low
    localparam logic [1:0] ph_down = 2'd3;         // delay before ack fall

    logic [instr_w-1:0] mem [0:(1<<pc_w)-1];       // program, loaded by the testbench
    logic [1:0]         phase    = ph_idle;
    int unsigned        wait_cnt = 0;
    logic               run      = 1'b0;           // reset seen at posedge
    logic               ack_r    = 1'b0;
    logic [instr_w-1:0] data_r   = '0;

    // rst_n sampled away from the driving edge
    always @(posedge clk) begin
        run <= rst_n;
    end

    always @(negedge clk) begin
        if (!run) begin
            ack_r <= 1'b0;
            phase <= ph_idle;
        end else begin
            case (phase)
                ph_idle: if (req) begin
                    wait_cnt <= $urandom_range(3, 0);
                    phase    <= ph_up;
                end
                ph_up: if (wait_cnt == 0) begin
                    data_r <= mem[addr];           // data valid with ack
                    ack_r  <= 1'b1;
                    phase  <= ph_hold;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
                ph_hold: if (!req) begin
                    wait_cnt <= $urandom_range(3, 0);
                    phase    <= ph_down;
                end
                ph_down: if (wait_cnt == 0) begin
                    ack_r <= 1'b0;                 // handshake closed
                    phase <= ph_idle;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    assign ack  = ack_r;
    assign data = data_r;

endmodule

// ==== verif/cpu_tb.sv ====
// cpu testbench
// directed programs run against a reference model of the instruction set,
// write-back and fetch addresses checked on every retire

module cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam int n_basic  = 2;
    localparam int n_arith  = 8;
    localparam int n_logic  = 8;
    localparam int n_shift  = 34;
    localparam int n_branch = 10;
    localparam int n_mix    = 24;
    localparam int n_total  = n_basic + n_arith + n_logic + n_shift + n_branch + n_mix;
    localparam int watchdog_cycles = 200 * n_total;

    logic              clk   = 1'b0;
    logic              rst_n = 1'b0;
    logic              imem_ack;
    instr_t            imem_data;
    logic              imem_req;
    logic [pc_w-1:0]   imem_addr;
    logic              retire;
    logic              wb_en;
    logic [reg_aw-1:0] wb_addr;
    logic [data_w-1:0] wb_data;

    logic [instr_w-1:0] prog [0:(1<<pc_w)-1];     // program image for the model
    logic [data_w-1:0]  m_regs [0:7];              // model register file
    logic [pc_w-1:0]    m_pc;
    logic               req_q  = 1'b0;
    logic [pc_w-1:0]    addr_q = '0;

    always #10 clk = ~clk;                         // 20 ns period

    cpu_top u_cpu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .retire    (retire),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    imem_model u_imem_model (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (imem_req),
        .addr  (imem_addr),
        .ack   (imem_ack),
        .data  (imem_data)
    );

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [31:0] enc(input logic [7:0] op, input logic [7:0] f1,
                                        input logic [7:0] f2, input logic [7:0] f3);
        return {op, f1, f2, f3};                   // opcode, rd or offset, rt, rs or imm
    endfunction

    // reference rules for one instruction and the model state update
    task automatic model_step(input logic [31:0] w, output logic en,
                              output logic [2:0] rd, output logic [7:0] val);
        logic [7:0] op;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] imm;
        logic [15:0] prod;
        logic       take;
        int         s;
        op   = w[31:24];
        rd   = w[18:16];                           // low bits of rd field
        a    = m_regs[w[10:8]];
        b    = m_regs[w[2:0]];
        imm  = w[7:0];
        s    = int'(imm[2:0]);
        en   = 1'b1;
        take = 1'b0;
        val  = '0;
        case (op)
            op_loadi: val = imm;
            op_mov:   val = b;
            op_add:   val = a + b;
            op_sub:   val = a - b;                 // wraps below zero
            op_and:   val = a & b;
            op_or:    val = a | b;
            op_mult: begin
                prod = 16'(a) * 16'(b);
                val  = prod[7:0];
            end
            op_sll:   val = a << s;
            op_srl:   val = a >> s;
            op_sra: begin
                val = a;
                for (int i = 0; i < s; i++) val = {val[7], val[7:1]};
            end
            op_ror: begin
                val = a;
                for (int i = 0; i < s; i++) val = {val[0], val[7:1]};
            end
            op_j: begin
                en   = 1'b0;
                take = 1'b1;
            end
            op_beq: begin
                en   = 1'b0;
                take = (a == b);
            end
            op_bne: begin
                en   = 1'b0;
                take = (a != b);
            end
            default: en = 1'b0;                    // no-op
        endcase
        if (en) m_regs[rd] = val;
        m_pc = m_pc + 8'd1 + (take ? w[23:16] : 8'd0);  // mod 256 equals signed add
    endtask

    task automatic clear_prog;
        for (int i = 0; i < (1 << pc_w); i++) begin
            prog[i] = {8'hff, 16'h0000, 8'(i)};    // unknown opcode tagged by address
        end
    endtask

    task automatic run_program(input int n, input string name);
        logic       en;
        logic [2:0] rd;
        logic [7:0] val;
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < (1 << pc_w); i++) u_imem_model.mem[i] = prog[i];
        for (int i = 0; i < 8; i++) m_regs[i] = '0;
        m_pc = '0;
        repeat (2) begin
            @(negedge clk);
            check(imem_req, 0, {name, ": req in reset"});
            check(retire, 0, {name, ": retire in reset"});
            check(wb_en, 0, {name, ": wb_en in reset"});
        end
        rst_n = 1'b1;
        do @(negedge clk); while (!imem_req);
        check(imem_addr, 0, {name, ": first fetch address"});
        for (int k = 0; k < n; k++) begin
            do begin
                @(negedge clk);
                if (!retire) check(wb_en, 0, {name, ": wb_en without retire"});
            end while (!retire);
            check(imem_addr, m_pc, {name, ": fetch address"});
            model_step(prog[m_pc], en, rd, val);
            check(wb_en, en, {name, ": wb_en"});
            if (en) begin
                check(wb_addr, rd, {name, ": wb_addr"});
                check(wb_data, val, {name, ": wb_data"});
            end
        end
    endtask

    task automatic reset_and_first_fetch;
        clear_prog();
        prog[0] = enc(op_loadi, 8'd1, 8'd0, 8'h5a);
        prog[1] = enc(op_mov, 8'd2, 8'd0, 8'd1);
        run_program(n_basic, "reset");
    endtask

    task automatic arith_ops;
        clear_prog();
        prog[0] = enc(op_loadi, 8'd1, 8'd0, 8'd20);
        prog[1] = enc(op_loadi, 8'd2, 8'd0, 8'd7);
        prog[2] = enc(op_mov, 8'd3, 8'd0, 8'd2);
        prog[3] = enc(op_add, 8'd4, 8'd1, 8'd2);
        prog[4] = enc(op_sub, 8'd5, 8'd2, 8'd1);  // goes negative
        prog[5] = enc(op_sub, 8'd6, 8'd1, 8'd2);
        prog[6] = enc(op_loadi, 8'd7, 8'd0, 8'hff);
        prog[7] = enc(op_add, 8'd0, 8'd7, 8'd7);  // carry out dropped
        run_program(n_arith, "arith");
    endtask

    task automatic logic_ops;
        logic [7:0] x;
        logic [7:0] y;
        x = 8'($urandom);
        y = 8'($urandom);
        clear_prog();
        prog[0] = enc(op_loadi, 8'd1, 8'd0, x);
        prog[1] = enc(op_loadi, 8'd2, 8'd0, y);
        prog[2] = enc(op_and, 8'd3, 8'd1, 8'd2);
        prog[3] = enc(op_or, 8'd4, 8'd1, 8'd2);
        prog[4] = enc(op_mult, 8'd5, 8'd1, 8'd2);
        prog[5] = enc(op_loadi, 8'd6, 8'd0, 8'hc8);
        prog[6] = enc(op_loadi, 8'd7, 8'd0, 8'h64);
        prog[7] = enc(op_mult, 8'd0, 8'd6, 8'd7); // high byte of 200 * 100 lost
        run_program(n_logic, "logic");
    endtask

    task automatic shift_ops;
        int         idx;
        logic [7:0] src;
        clear_prog();
        prog[0] = enc(op_loadi, 8'd1, 8'd0, 8'($urandom) | 8'h80);  // sign set
        prog[1] = enc(op_loadi, 8'd6, 8'd0, 8'($urandom) & 8'h7f);  // sign clear
        idx = 2;
        for (int s = 0; s < 8; s++) begin
            src = (s % 2 == 1) ? 8'd6 : 8'd1;
            prog[idx]     = enc(op_sll, 8'd2, src, 8'(s));
            prog[idx + 1] = enc(op_srl, 8'd3, src, 8'(s));
            prog[idx + 2] = enc(op_sra, 8'd4, src, 8'(s));
            prog[idx + 3] = enc(op_ror, 8'd5, src, 8'(s));
            idx += 4;
        end
        run_program(n_shift, "shifts");
    endtask

    task automatic branch_flow;
        clear_prog();
        prog[0]  = enc(op_loadi, 8'd1, 8'd0, 8'd3);
        prog[1]  = enc(op_loadi, 8'd2, 8'd0, 8'd3);
        prog[2]  = enc(op_j, 8'd2, 8'd0, 8'd0);   // forward to 5
        prog[3]  = enc(op_loadi, 8'd7, 8'd0, 8'hee);
        prog[4]  = enc(op_j, 8'd8, 8'd0, 8'd0);   // out to 13
        prog[5]  = enc(op_beq, 8'd1, 8'd1, 8'd2); // taken to 7
        prog[6]  = enc(op_loadi, 8'd7, 8'd0, 8'h11);
        prog[7]  = enc(op_bne, 8'd3, 8'd1, 8'd2); // not taken
        prog[8]  = enc(op_beq, 8'd3, 8'd1, 8'd3); // not taken
        prog[9]  = enc(op_bne, 8'd2, 8'd1, 8'd3); // taken to 12
        prog[10] = enc(op_loadi, 8'd7, 8'd0, 8'h22);
        prog[11] = enc(op_loadi, 8'd7, 8'd0, 8'h33);
        prog[12] = enc(op_j, 8'hf7, 8'd0, 8'd0);  // back to 4
        prog[13] = enc(op_loadi, 8'd6, 8'd0, 8'h5a);
        run_program(n_branch, "branches");
    endtask

    task automatic random_mix;
        logic [7:0] ops [0:9];
        ops = '{op_mov, op_add, op_sub, op_and, op_or,
                op_mult, op_sll, op_srl, op_sra, op_ror};
        clear_prog();
        for (int i = 0; i < 8; i++) prog[i] = enc(op_loadi, 8'(i), 8'd0, 8'($urandom));
        for (int i = 8; i < n_mix; i++) begin
            // random fields with only the low bits used
            prog[i] = enc(ops[$urandom_range(9, 0)], 8'($urandom), 8'($urandom), 8'($urandom));
        end
        run_program(n_mix, "mix");
    endtask

    // address hold while req stays high
    always @(negedge clk) begin
        if (rst_n && imem_req && req_q) begin
            check(imem_addr, addr_q, "imem_addr changed while req high");
        end
        req_q  <= imem_req;
        addr_q <= imem_addr;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'h9ac9_b8fd));
        reset_and_first_fetch();
        arith_ops();
        logic_ops();
        shift_ops();
        branch_flow();
        random_mix();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/cpu_pkg.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/pc_unit.sv
rtl/cpu_fsm.sv
rtl/cpu_top.sv
verif/imem_model.sv
verif/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module cpu_tb -f src.f -o cpu_sim

./obj_dir/cpu_sim | tee sim.log

grep -q "ALL TESTS PASSED" sim.log
echo "simulation passed"
